/* Makefile */
TOP       ?= tb_tc_top
FILELIST  ?= src.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* src.f */
tc_pkg.sv
tc_pe.sv
tc_operand_buf.sv
tc_systolic.sv
tc_ctrl.sv
tc_axil_regs.sv
tc_top.sv
tb_tc_top.sv

/* tb_tc_top.sv */
`timescale 1ns/1ns

module tb_tc_top import tc_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 7;
    localparam int TEST_BUDGET  = 2000; // Cycles per test
    localparam int POLL_LIMIT   = 200;
    localparam int STALL_LEN    = 5;
    localparam int FILL_IDENT   = 0;
    localparam int FILL_PATTERN = 1;
    localparam int FILL_RANDOM  = 2;
    localparam int EXTRA_NONE   = 0;
    localparam int EXTRA_BUSY   = 1;
    localparam int EXTRA_STALL  = 2;

    logic                    clk;
    logic                    rst;
    logic                    awvalid;
    logic                    awready;
    logic [AXI_ADDR_W-1:0]   awaddr;
    logic                    wvalid;
    logic                    wready;
    logic [AXI_DATA_W-1:0]   wdata;
    logic [AXI_DATA_W/8-1:0] wstrb;
    logic                    bvalid;
    logic                    bready;
    logic [1:0]              bresp;
    logic                    arvalid;
    logic                    arready;
    logic [AXI_ADDR_W-1:0]   araddr;
    logic                    rvalid;
    logic                    rready;
    logic [AXI_DATA_W-1:0]   rdata;
    logic [1:0]              rresp;

    string         test_name [NUM_TESTS];
    mode_t         test_mode [NUM_TESTS];
    int            test_fill [NUM_TESTS];
    int            test_extra [NUM_TESTS];
    operand_word_t a_words [BUF_WORDS];
    operand_word_t b_words [BUF_WORDS];
    acc_t          c_ref [TC_DIM][TC_DIM];
    string         cur_name;
    int            seed;
    int            stall_cycles;
    int            errors;
    int            tests_failed;

    tc_top tc_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_TESTS * TEST_BUDGET + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within their cycle budget");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic load_table();
        test_name  = '{"ident_int8", "rand_int8", "rand_int4", "pattern_int8",
                       "pattern_int4", "busy_protocol", "backpressure"};
        test_mode  = '{MODE_INT8, MODE_INT8, MODE_INT4, MODE_INT8,
                       MODE_INT4, MODE_INT8, MODE_INT4};
        test_fill  = '{FILL_IDENT, FILL_RANDOM, FILL_RANDOM, FILL_PATTERN,
                       FILL_PATTERN, FILL_RANDOM, FILL_RANDOM};
        test_extra = '{EXTRA_NONE, EXTRA_NONE, EXTRA_NONE, EXTRA_NONE,
                       EXTRA_NONE, EXTRA_BUSY, EXTRA_STALL};
    endtask

    task automatic report_error(input string msg);
        $display("Error in %s: %s", cur_name, msg);
        errors++;
    endtask

    task automatic check_acc(input string what, input acc_t expected, input acc_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %0d, actual %0d", what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_word(input string what, input operand_word_t expected,
                              input operand_word_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_resp(input string what, input logic [1:0] expected,
                              input logic [1:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %0d, actual %0d", what, expected, actual);
            errors++;
        end
    endtask

    // Bus tasks start and end 1 ns after a rising edge
    task automatic axil_write(input logic [AXI_ADDR_W-1:0] addr,
                              input logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
        logic [1:0] held;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        #1;
        while (!awready) begin
            @(posedge clk);
            #1;
        end
        if (!wready) report_error("wready low while awready is high");
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (!bvalid) report_error("no write response after the handshake");
        held = bresp;
        for (int i = 0; i < stall_cycles; i++) begin
            @(posedge clk);
            #1;
            if (!bvalid || bresp !== held) report_error("write response moved while stalled");
        end
        bready = 1'b1;
        resp   = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [AXI_ADDR_W-1:0] addr,
                             output logic [AXI_DATA_W-1:0] data, output logic [1:0] resp);
        logic [AXI_DATA_W-1:0] held_data;
        logic [1:0]            held_resp;
        araddr  = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        if (!rvalid) report_error("no read data after the address handshake");
        held_data = rdata;
        held_resp = rresp;
        for (int i = 0; i < stall_cycles; i++) begin
            @(posedge clk);
            #1;
            if (!rvalid || rdata !== held_data || rresp !== held_resp) begin
                report_error("read response moved while stalled");
            end
        end
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic write_word(input logic [AXI_ADDR_W-1:0] addr,
                              input logic [AXI_DATA_W-1:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_resp($sformatf("%s write resp @%h", cur_name, addr), RESP_OKAY, resp);
    endtask

    task automatic read_word(input logic [AXI_ADDR_W-1:0] addr,
                             output logic [AXI_DATA_W-1:0] data);
        logic [1:0] resp;
        axil_read(addr, data, resp);
        check_resp($sformatf("%s read resp @%h", cur_name, addr), RESP_OKAY, resp);
    endtask

    function automatic logic [AXI_ADDR_W-1:0] word_addr(input logic [AXI_ADDR_W-1:0] base,
                                                         input int idx);
        return base + AXI_ADDR_W'(4 * idx);
    endfunction

    function automatic logic [AXI_DATA_W-1:0] start_word(input mode_t m);
        return AXI_DATA_W'({m, 1'b1});
    endfunction

    function automatic operand_word_t pattern_word(input int which, input int idx);
        return operand_word_t'(32'h1357_9BDF * 32'(idx + 1) + 32'(which) * 32'h0F1E_2D3C);
    endfunction

    // Signed lane products from the raw two's complement fields
    function automatic acc_t lane_dot(input operand_word_t a, input operand_word_t b,
                                      input mode_t m);
        int sum;
        int av;
        int bv;
        sum = 0;
        for (int l = 0; l < INT4_LANES; l++) begin
            if (m == MODE_INT4) begin
                av = int'(a.s4[l]);
                bv = int'(b.s4[l]);
                if (av > 7) av -= 16;
                if (bv > 7) bv -= 16;
                sum += av * bv;
            end else if (l < INT8_LANES) begin
                av = int'(a.s8[l]);
                bv = int'(b.s8[l]);
                if (av > 127) av -= 256;
                if (bv > 127) bv -= 256;
                sum += av * bv;
            end
        end
        return acc_t'(sum);
    endfunction

    function automatic acc_t ref_element(input int r, input int c, input mode_t m);
        acc_t sum;
        sum = '0;
        for (int k = 0; k < K_WORDS; k++) begin
            sum += lane_dot(a_words[r * K_WORDS + k], b_words[c * K_WORDS + k], m);
        end
        return sum;
    endfunction

    task automatic fill_operands(input int kind, input int salt);
        for (int idx = 0; idx < BUF_WORDS; idx++) begin
            if (kind == FILL_IDENT) begin
                a_words[idx] = '0;
                if (idx % K_WORDS == idx / K_WORDS) a_words[idx].s8[idx / K_WORDS] = 8'd1;
                b_words[idx] = pattern_word(salt + 1, idx);
            end else if (kind == FILL_PATTERN) begin
                a_words[idx] = pattern_word(salt, idx);
                b_words[idx] = pattern_word(salt + 7, idx);
            end else begin
                a_words[idx] = operand_word_t'($random(seed));
                b_words[idx] = operand_word_t'($random(seed));
                if (idx % 5 == 0) begin // Extreme INT8 lanes
                    a_words[idx].s8[0] = 8'h80;
                    a_words[idx].s8[3] = 8'h7F;
                    b_words[idx].s8[0] = 8'h80;
                    b_words[idx].s8[2] = 8'h7F;
                end
            end
        end
    endtask

    task automatic check_unmapped();
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        axil_read(12'h050, data, resp);
        check_resp({cur_name, " read 0x050"}, RESP_SLVERR, resp);
        axil_read(12'h340, data, resp);
        check_resp({cur_name, " read 0x340"}, RESP_SLVERR, resp);
        axil_write(12'h400, 32'hDEAD_BEEF, resp);
        check_resp({cur_name, " write 0x400"}, RESP_SLVERR, resp);
    endtask

    task automatic run_test(input int t);
        logic [AXI_DATA_W-1:0] data;
        logic [AXI_DATA_W-1:0] kept;
        int                    polls;
        int                    diffs;
        int                    first_error;
        mode_t                 m;
        cur_name     = test_name[t];
        m            = test_mode[t];
        first_error  = errors;
        diffs        = 0;
        stall_cycles = (test_extra[t] == EXTRA_STALL) ? STALL_LEN : 0;
        fill_operands(test_fill[t], t);
        if (test_extra[t] == EXTRA_BUSY) check_unmapped();
        for (int idx = 0; idx < BUF_WORDS; idx++) begin
            write_word(word_addr(A_BASE, idx), a_words[idx]);
            write_word(word_addr(B_BASE, idx), b_words[idx]);
        end
        write_word(REG_CTRL, start_word(m));
        if (test_extra[t] == EXTRA_BUSY) begin
            kept = a_words[0];
            write_word(word_addr(A_BASE, 0), ~kept); // Dropped while busy
            write_word(REG_CTRL, start_word((m == MODE_INT8) ? MODE_INT4 : MODE_INT8));
        end
        read_word(REG_STATUS, data);
        check_word({cur_name, " STATUS in run"}, operand_word_t'(32'h1), operand_word_t'(data));
        polls = 0;
        do begin
            read_word(REG_STATUS, data);
            polls++;
        end while (!data[STATUS_DONE_BIT] && polls < POLL_LIMIT);
        if (!data[STATUS_DONE_BIT]) begin
            report_error("done never rose after start");
        end
        check_word({cur_name, " STATUS after run"}, operand_word_t'(32'h2), operand_word_t'(data));
        if (test_extra[t] == EXTRA_BUSY) begin
            read_word(REG_CTRL, data);
            check_word({cur_name, " CTRL mode"}, operand_word_t'(start_word(m) & 32'h2),
                       operand_word_t'(data));
        end
        for (int r = 0; r < TC_DIM; r++) begin
            for (int c = 0; c < TC_DIM; c++) begin
                c_ref[r][c] = ref_element(r, c, m);
                read_word(word_addr(C_BASE, r * TC_DIM + c), data);
                if (acc_t'(data) != ref_element(r, c, MODE_INT8)) diffs++;
                check_acc($sformatf("%s C[%0d][%0d]", cur_name, r, c), c_ref[r][c],
                          acc_t'(data));
            end
        end
        if (m == MODE_INT4 && diffs == 0) begin
            report_error("INT4 results all equal the INT8 decode of the same words");
        end
        for (int idx = 0; idx < BUF_WORDS; idx++) begin
            read_word(word_addr(A_BASE, idx), data);
            check_word($sformatf("%s A[%0d]", cur_name, idx), a_words[idx],
                       operand_word_t'(data));
            read_word(word_addr(B_BASE, idx), data);
            check_word($sformatf("%s B[%0d]", cur_name, idx), b_words[idx],
                       operand_word_t'(data));
        end
        stall_cycles = 0;
        if (errors == first_error) begin
            $display("PASS %s (%0d of %0d C elements differ from INT8 decode)",
                     cur_name, diffs, C_WORDS);
        end else begin
            $display("FAIL %s with %0d errors", cur_name, errors - first_error);
            tests_failed++;
        end
    endtask

    initial begin
        seed         = 28;
        stall_cycles = 0;
        errors       = 0;
        tests_failed = 0;
        cur_name     = "reset";
        rst          = 1'b0;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        wstrb        = '1;
        bready       = 1'b0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b1;
        @(posedge clk);
        #1;
        if (bvalid || rvalid || awready || wready || !arready) begin
            report_error("bus handshake outputs not idle after reset");
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests: %0d run, %0d passed, %0d failed, %0d check errors",
                 NUM_TESTS, NUM_TESTS - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* tc_axil_regs.sv */
`timescale 1ns/1ns

module tc_axil_regs import tc_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [AXI_ADDR_W-1:0]         awaddr,
    input  logic                          wvalid,
    output logic                          wready,
    input  logic [AXI_DATA_W-1:0]         wdata,
    input  logic [AXI_DATA_W/8-1:0]       wstrb,
    output logic                          bvalid,
    input  logic                          bready,
    output logic [1:0]                    bresp,
    input  logic                          arvalid,
    output logic                          arready,
    input  logic [AXI_ADDR_W-1:0]         araddr,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [AXI_DATA_W-1:0]         rdata,
    output logic [1:0]                    rresp,
    input  logic                          busy,
    input  logic                          done,
    input  acc_t [TC_DIM-1:0][TC_DIM-1:0] c_result,
    output logic                          start_pulse,
    output mode_t                         mode,
    output logic                          buf_we_a,
    output logic                          buf_we_b,
    output logic [BUF_IDX_W-1:0]          buf_index,
    output operand_word_t                 buf_wdata
);

    logic                 wr_fire;
    logic                 rd_fire;
    logic                 aw_ctrl;
    logic                 aw_a;
    logic                 aw_b;
    logic                 aw_hit;
    logic                 ar_a;
    logic                 ar_b;
    logic                 ar_c;
    logic [C_IDX_W-1:0]   c_idx;
    logic                 rd_hit;
    logic [AXI_DATA_W-1:0] rd_word;
    operand_word_t        a_copy [BUF_WORDS];
    operand_word_t        b_copy [BUF_WORDS];

    function automatic logic in_region(input logic [AXI_ADDR_W-1:0] addr,
                                       input logic [AXI_ADDR_W-1:0] base,
                                       input int words);
        return (addr >= base) && (addr < base + AXI_ADDR_W'(4 * words));
    endfunction

    // Write channel accepts address and data together
    assign wr_fire   = awvalid && wvalid && !bvalid;
    assign awready   = wr_fire;
    assign wready    = wr_fire;

    assign aw_ctrl   = (awaddr == REG_CTRL);
    assign aw_a      = in_region(awaddr, A_BASE, BUF_WORDS);
    assign aw_b      = in_region(awaddr, B_BASE, BUF_WORDS);
    assign aw_hit    = aw_ctrl || (awaddr == REG_STATUS) || aw_a || aw_b ||
                       in_region(awaddr, C_BASE, C_WORDS);

    assign buf_index = awaddr[BUF_IDX_W+1:2];
    assign buf_wdata = wdata;
    assign buf_we_a  = wr_fire && aw_a && !busy; // Ignored mid-run yet answered OKAY
    assign buf_we_b  = wr_fire && aw_b && !busy;

    always_ff @(posedge clk) begin
        if (!rst) begin
            bvalid      <= 1'b0;
            start_pulse <= 1'b0;
            mode        <= MODE_INT8;
        end else begin
            start_pulse <= 1'b0;
            if (wr_fire) begin
                bvalid <= 1'b1;
                if (aw_ctrl) begin
                    start_pulse <= wdata[CTRL_START_BIT];
                    if (!busy) begin
                        mode <= mode_t'(wdata[CTRL_MODE_BIT]); // Held for the whole run
                    end
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= aw_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Host-side copies for operand readback
    always_ff @(posedge clk) begin
        if (buf_we_a) begin
            a_copy[buf_index] <= buf_wdata;
        end
        if (buf_we_b) begin
            b_copy[buf_index] <= buf_wdata;
        end
    end

    // Read channel
    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    assign ar_a  = in_region(araddr, A_BASE, BUF_WORDS);
    assign ar_b  = in_region(araddr, B_BASE, BUF_WORDS);
    assign ar_c  = in_region(araddr, C_BASE, C_WORDS);
    assign c_idx = araddr[C_IDX_W+1:2];

    always_comb begin
        rd_word = '0;
        rd_hit  = 1'b1;
        if (araddr == REG_CTRL) begin
            rd_word[CTRL_MODE_BIT] = mode;
        end else if (araddr == REG_STATUS) begin
            rd_word[STATUS_BUSY_BIT] = busy;
            rd_word[STATUS_DONE_BIT] = done;
        end else if (ar_a) begin
            rd_word = a_copy[araddr[BUF_IDX_W+1:2]];
        end else if (ar_b) begin
            rd_word = b_copy[araddr[BUF_IDX_W+1:2]];
        end else if (ar_c) begin
            rd_word = c_result[c_idx / TC_DIM][c_idx % TC_DIM]; // Row major
        end else begin
            rd_hit = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

/* tc_ctrl.sv */
`timescale 1ns/1ns

module tc_ctrl import tc_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_pulse,
    output logic              busy,
    output logic              done,
    output logic              feed_valid,
    output logic [STEP_W-1:0] feed_step,
    output logic              acc_clear
);

    ctrl_state_t        state;
    logic [STEP_W-1:0]  step_cnt;
    logic [DRAIN_W-1:0] drain_cnt;

    assign busy       = (state == ST_FEED) || (state == ST_DRAIN);
    assign done       = (state == ST_DONE);
    assign feed_valid = (state == ST_FEED) && !acc_clear; // First feed cycle only clears
    assign feed_step  = step_cnt;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= ST_IDLE;
            acc_clear <= 1'b0;
            step_cnt  <= '0;
            drain_cnt <= '0;
        end else begin
            acc_clear <= 1'b0;
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (start_pulse) begin
                        state     <= ST_FEED;
                        acc_clear <= 1'b1;
                        step_cnt  <= '0;
                    end
                end
                ST_FEED: begin
                    if (feed_valid) begin
                        if (step_cnt == STEP_W'(FEED_STEPS - 1)) begin
                            state     <= ST_DRAIN;
                            drain_cnt <= '0;
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                        end
                    end
                end
                ST_DRAIN: begin
                    // Wait for the last word to reach the far corner
                    if (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1)) begin
                        state <= ST_DONE;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* tc_operand_buf.sv */
`timescale 1ns/1ns

module tc_operand_buf import tc_pkg::*; (
    input  logic                       clk,
    input  logic                       we,
    input  logic [BUF_IDX_W-1:0]       index,
    input  operand_word_t              wdata,
    input  logic [STEP_W-1:0]          step,
    output operand_word_t [TC_DIM-1:0] lanes
);

    // Lane-major layout with word k of lane l at l*K_WORDS+k
    operand_word_t mem [BUF_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    // Same-cycle read of one word per lane
    always_comb begin
        for (int l = 0; l < TC_DIM; l++) begin
            lanes[l] = mem[l * K_WORDS + int'(step)];
        end
    end

endmodule

/* tc_pe.sv */
`timescale 1ns/1ns

module tc_pe import tc_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  mode_t         mode,
    input  logic          acc_clear,
    input  operand_word_t a_in,
    input  operand_word_t b_in,
    input  logic          valid_in,
    output operand_word_t a_out,
    output operand_word_t b_out,
    output logic          valid_out,
    output acc_t          acc
);

    acc_t dot;

    // Lane-wise signed dot product of one word pair
    always_comb begin
        dot = '0;
        if (mode == MODE_INT4) begin
            for (int l = 0; l < INT4_LANES; l++) begin
                dot = dot + acc_t'($signed(a_in.s4[l])) * acc_t'($signed(b_in.s4[l]));
            end
        end else begin
            for (int l = 0; l < INT8_LANES; l++) begin
                dot = dot + acc_t'($signed(a_in.s8[l])) * acc_t'($signed(b_in.s8[l]));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_out <= 1'b0;
            acc       <= '0;
        end else begin
            valid_out <= valid_in;
            if (acc_clear) begin
                acc <= '0;
            end else if (valid_in) begin
                acc <= acc + dot;
            end
        end
    end

    // Operands move on to the right and downward neighbours
    always_ff @(posedge clk) begin
        a_out <= a_in;
        b_out <= b_in;
    end

endmodule

/* tc_pkg.sv */
package tc_pkg;

    // Array geometry
    localparam int TC_DIM     = 4;
    localparam int K_WORDS    = 4;
    localparam int INT8_LANES = 4;
    localparam int INT4_LANES = 8;

    // Host bus
    localparam int AXI_ADDR_W = 12;
    localparam int AXI_DATA_W = 32;

    // Run timing
    localparam int FEED_STEPS   = K_WORDS;
    localparam int DRAIN_CYCLES = 2 * (TC_DIM - 1) + 1; // Skew plus pass-through to far corner

    // Counter and index widths
    localparam int STEP_W    = $clog2(FEED_STEPS);
    localparam int DRAIN_W   = $clog2(DRAIN_CYCLES);
    localparam int BUF_WORDS = TC_DIM * K_WORDS;
    localparam int BUF_IDX_W = $clog2(BUF_WORDS);
    localparam int C_WORDS   = TC_DIM * TC_DIM;
    localparam int C_IDX_W   = $clog2(C_WORDS);

    // Register map in byte offsets
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL   = 12'h000;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 12'h004;
    localparam logic [AXI_ADDR_W-1:0] A_BASE     = 12'h100;
    localparam logic [AXI_ADDR_W-1:0] B_BASE     = 12'h200;
    localparam logic [AXI_ADDR_W-1:0] C_BASE     = 12'h300;

    localparam int CTRL_START_BIT  = 0; // Write only, self clearing
    localparam int CTRL_MODE_BIT   = 1;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // One operand word of two's complement lanes with lane 0 lowest
    typedef union packed {
        logic [INT8_LANES-1:0][7:0] s8;
        logic [INT4_LANES-1:0][3:0] s4;
    } operand_word_t;

    typedef logic signed [31:0] acc_t;

    typedef enum logic [0:0] {
        MODE_INT8 = 1'b0,
        MODE_INT4 = 1'b1
    } mode_t;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_FEED  = 2'd1,
        ST_DRAIN = 2'd2,
        ST_DONE  = 2'd3
    } ctrl_state_t;

endpackage

/* tc_systolic.sv */
`timescale 1ns/1ns

module tc_systolic import tc_pkg::*; (
    input  logic                          clk,
    input  logic                          rst,
    input  mode_t                         mode,
    input  logic                          feed_valid,
    input  logic                          acc_clear,
    input  operand_word_t [TC_DIM-1:0]    a_lanes,
    input  operand_word_t [TC_DIM-1:0]    b_lanes,
    output acc_t [TC_DIM-1:0][TC_DIM-1:0] c_result
);

    // Index [r][c] feeds element (r,c) and the extra edge catches the outputs
    operand_word_t a_grid [TC_DIM][TC_DIM+1];
    operand_word_t b_grid [TC_DIM+1][TC_DIM];
    logic          v_grid [TC_DIM][TC_DIM+1]; // Valid travels with A

    for (genvar i = 0; i < TC_DIM; i++) begin : g_skew
        if (i == 0) begin : g_direct
            assign a_grid[i][0] = a_lanes[i];
            assign b_grid[0][i] = b_lanes[i];
            assign v_grid[i][0] = feed_valid;
        end else begin : g_delay
            operand_word_t a_pipe [i];
            operand_word_t b_pipe [i];
            logic [i-1:0]  v_pipe;

            always_ff @(posedge clk) begin
                a_pipe[0] <= a_lanes[i];
                b_pipe[0] <= b_lanes[i];
                for (int d = 1; d < i; d++) begin
                    a_pipe[d] <= a_pipe[d-1];
                    b_pipe[d] <= b_pipe[d-1];
                end
            end

            always_ff @(posedge clk) begin
                if (!rst) begin
                    v_pipe <= '0;
                end else begin
                    v_pipe[0] <= feed_valid;
                    for (int d = 1; d < i; d++) begin
                        v_pipe[d] <= v_pipe[d-1];
                    end
                end
            end

            assign a_grid[i][0] = a_pipe[i-1]; // Row i late by i cycles
            assign b_grid[0][i] = b_pipe[i-1];
            assign v_grid[i][0] = v_pipe[i-1];
        end
    end

    for (genvar r = 0; r < TC_DIM; r++) begin : g_row
        for (genvar c = 0; c < TC_DIM; c++) begin : g_col
            tc_pe pe_inst (
                .clk       (clk),
                .rst       (rst),
                .mode      (mode),
                .acc_clear (acc_clear),
                .a_in      (a_grid[r][c]),
                .b_in      (b_grid[r][c]),
                .valid_in  (v_grid[r][c]),
                .a_out     (a_grid[r][c+1]),
                .b_out     (b_grid[r+1][c]),
                .valid_out (v_grid[r][c+1]),
                .acc       (c_result[r][c])
            );
        end
    end

endmodule

/* tc_top.sv */
`timescale 1ns/1ns

module tc_top import tc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [AXI_ADDR_W-1:0]   awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [AXI_DATA_W-1:0]   wdata,
    input  logic [AXI_DATA_W/8-1:0] wstrb,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [AXI_ADDR_W-1:0]   araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [AXI_DATA_W-1:0]   rdata,
    output logic [1:0]              rresp
);

    logic                               start_pulse;
    mode_t                              mode;
    logic                               busy;
    logic                               done;
    logic                               feed_valid;
    logic [STEP_W-1:0]                  feed_step;
    logic                               acc_clear;
    logic                               buf_we_a;
    logic                               buf_we_b;
    logic [BUF_IDX_W-1:0]               buf_index;
    operand_word_t                      buf_wdata;
    operand_word_t [TC_DIM-1:0]         a_lanes;
    operand_word_t [TC_DIM-1:0]         b_lanes;
    acc_t [TC_DIM-1:0][TC_DIM-1:0]      c_result;

    tc_axil_regs regs_inst (
        .clk         (clk),
        .rst         (rst),
        .awvalid     (awvalid),
        .awready     (awready),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wready      (wready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .arvalid     (arvalid),
        .arready     (arready),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .busy        (busy),
        .done        (done),
        .c_result    (c_result),
        .start_pulse (start_pulse),
        .mode        (mode),
        .buf_we_a    (buf_we_a),
        .buf_we_b    (buf_we_b),
        .buf_index   (buf_index),
        .buf_wdata   (buf_wdata)
    );

    tc_ctrl ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .busy        (busy),
        .done        (done),
        .feed_valid  (feed_valid),
        .feed_step   (feed_step),
        .acc_clear   (acc_clear)
    );

    tc_operand_buf buf_a (
        .clk   (clk),
        .we    (buf_we_a),
        .index (buf_index),
        .wdata (buf_wdata),
        .step  (feed_step),
        .lanes (a_lanes)    // One word per row of A
    );

    tc_operand_buf buf_b (
        .clk   (clk),
        .we    (buf_we_b),
        .index (buf_index),
        .wdata (buf_wdata),
        .step  (feed_step),
        .lanes (b_lanes)    // One word per column of B
    );

    tc_systolic systolic_inst (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .feed_valid (feed_valid),
        .acc_clear  (acc_clear),
        .a_lanes    (a_lanes),
        .b_lanes    (b_lanes),
        .c_result   (c_result)
    );

endmodule
